// ==== filelist.f ====
logic/io_port_pkg.sv
logic/io_request_stage.sv
logic/port_decode_stage.sv
logic/io_response_stage.sv
logic/io_port_fabric.sv
test/io_port_fabric_sva.sv
test/io_port_fabric_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module io_port_fabric_tb \
	-f filelist.f \
	-o io_port_fabric_sim

./obj_dir/io_port_fabric_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
grep -q "TESTBENCH PASSED" sim.log

// ==== test/io_port_fabric_tb.sv ====
`timescale 1ns/100ps

module io_port_fabric_tb;

typedef struct packed {
	io_port_pkg::io_rsp_t rsp;
	logic [7:0]           syscfg;
	logic                 device;
	io_port_pkg::io_req_t req;
} expect_t;

logic                 clk_sys;
logic                 reset;
io_port_pkg::io_req_t req;
logic                 req_valid;
logic                 req_ready;
io_port_pkg::io_rsp_t rsp;
logic                 rsp_valid;
logic                 rsp_ready;
io_port_pkg::io_dec_t dev_req;
logic                 dev_valid;
logic                 dev_done;
logic [31:0]          dev_rdata;
logic [7:0]           syscfg;

expect_t              exp_q[$];
expect_t              exp_head;
expect_t              exp_new;
int                   exp_count;
logic [7:0]           exp_cfg;
logic                 exp_in_reset;
io_port_pkg::io_dev_e exp_dev;
int                   dev_done_count;
int                   dev_rsp_count;
int                   dev_wait;
logic                 backpressure;
logic [15:0]          addr_pool[16];

io_port_fabric io_port_fabric_i
(
	.clk_sys   (clk_sys),
	.reset     (reset),
	.req       (req),
	.req_valid (req_valid),
	.req_ready (req_ready),
	.rsp       (rsp),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.dev_req   (dev_req),
	.dev_valid (dev_valid),
	.dev_done  (dev_done),
	.dev_rdata (dev_rdata),
	.syscfg    (syscfg)
);

function automatic logic in_range(logic [15:0] addr, logic [15:0] base, logic [15:0] span);
	return (addr >= base) && (addr < base + span);
endfunction

// port map of a PC, in decode priority order
function automatic io_port_pkg::io_dev_e expect_dev(logic [15:0] a);
	if (in_range(a, 16'h1F0, 8) || in_range(a, 16'h3F6, 2)) return io_port_pkg::dev_ide0;
	if (in_range(a, 16'h170, 8) || in_range(a, 16'h376, 2)) return io_port_pkg::dev_ide1;
	if (in_range(a, 16'h3F0, 8)) return io_port_pkg::dev_floppy;
	if (in_range(a, 16'h000, 16) || in_range(a, 16'h080, 16) || in_range(a, 16'h0C0, 32))
		return io_port_pkg::dev_dma;
	if (in_range(a, 16'h020, 2) || in_range(a, 16'h0A0, 2)) return io_port_pkg::dev_pic;
	if (in_range(a, 16'h040, 4) || in_range(a, 16'h061, 1)) return io_port_pkg::dev_pit;
	if (in_range(a, 16'h060, 8) || in_range(a, 16'h090, 16)) return io_port_pkg::dev_ps2;
	if (in_range(a, 16'h070, 2)) return io_port_pkg::dev_rtc;
	if (in_range(a, 16'h220, 16) || in_range(a, 16'h388, 4)) return io_port_pkg::dev_sound;
	if (in_range(a, 16'h3F8, 8) || in_range(a, 16'h330, 2)) return io_port_pkg::dev_uart;
	if (in_range(a, 16'h3B0, 48)) return io_port_pkg::dev_vga;
	if (in_range(a, 16'h201, 1)) return io_port_pkg::dev_joystick;
	if (a == 16'h8888) return io_port_pkg::dev_sysctl;
	return io_port_pkg::dev_none;
endfunction

// each port answers with a byte made from its address
function automatic logic [7:0] model_byte(logic [15:0] a);
	return a[7:0] ^ a[15:8] ^ 8'h3C;
endfunction

task automatic stop_run(string line);
	$display("%s", line);
	$display("TESTBENCH FAILED");
	$fatal(1);
endtask

task automatic fail_now(string msg);
	stop_run($sformatf("FAIL %0t: %s", $time, msg));
endtask

initial begin
	clk_sys = 1'b0;
	forever #50 clk_sys = ~clk_sys;
end

// device model with a random wait before each completion
always @(posedge clk_sys) begin
	if (reset || dev_done) begin
		dev_done <= 1'b0;
		dev_wait <= $urandom % 4;
	end
	else if (dev_valid) begin
		if (dev_wait == 0) begin
			dev_done  <= 1'b1;
			dev_rdata <= {4{model_byte(dev_req.req.address)}};
		end
		else begin
			dev_wait <= dev_wait - 1;
		end
	end
end

always @(posedge clk_sys) begin
	rsp_ready <= backpressure ? (($urandom % 4) != 0) : 1'b1;
end

// expected responses follow the requests in acceptance order
always @(posedge clk_sys) begin
	if (reset) begin
		exp_q.delete();
		exp_cfg        = 8'hA2;
		exp_in_reset   = 1'b1;
		dev_done_count <= 0;
		dev_rsp_count  <= 0;
	end
	else begin
		if (dev_valid && dev_done) begin
			dev_done_count <= dev_done_count + 1;
		end
		if (rsp_valid && rsp_ready && exp_q.size() != 0) begin
			if (exp_q[0].device) begin
				dev_rsp_count <= dev_rsp_count + 1;
			end
			void'(exp_q.pop_front());
		end
		if (req_valid && req_ready) begin
			exp_dev = expect_dev(req.address);
			exp_new.req = req;
			exp_new.device = !(exp_dev == io_port_pkg::dev_none ||
				exp_dev == io_port_pkg::dev_sysctl);
			exp_new.rsp.write = req.write;
			exp_new.rsp.dev   = exp_dev;
			if (req.write)
				exp_new.rsp.readdata = 32'd0;
			else if (exp_dev == io_port_pkg::dev_ide0 || exp_dev == io_port_pkg::dev_ide1)
				exp_new.rsp.readdata = {4{model_byte(req.address)}};
			else if (!exp_new.device)
				exp_new.rsp.readdata = 32'h0000_00FF;
			else
				exp_new.rsp.readdata = {24'd0, model_byte(req.address)};
			if (exp_in_reset && (exp_dev == io_port_pkg::dev_ide0 ||
				exp_dev == io_port_pkg::dev_ide1 || exp_dev == io_port_pkg::dev_floppy)) begin
				exp_cfg      = 8'h00;
				exp_in_reset = 1'b0;
			end
			else if (req.write && exp_dev == io_port_pkg::dev_sysctl &&
				req.size == io_port_pkg::size_word && req.writedata[15:8] == 8'hA1) begin
				exp_cfg      = req.writedata[7:0];
				exp_in_reset = 1'b0;
			end
			exp_new.syscfg = exp_cfg;
			exp_q.push_back(exp_new);
		end
	end
	exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
	exp_count <= exp_q.size();
end

rsp_matches: assert property (@(posedge clk_sys) disable iff (reset)
	(rsp_valid && rsp_ready) |-> (exp_count != 0 && rsp == exp_head.rsp))
	else fail_now($sformatf("response %h, expected %h", rsp, exp_head.rsp));

syscfg_matches: assert property (@(posedge clk_sys) disable iff (reset)
	(rsp_valid && rsp_ready) |-> (syscfg == exp_head.syscfg))
	else fail_now($sformatf("syscfg %h, expected %h", syscfg, exp_head.syscfg));

one_access_each: assert property (@(posedge clk_sys) disable iff (reset)
	(rsp_valid && rsp_ready) |-> (dev_done_count == dev_rsp_count + int'(exp_head.device)))
	else fail_now("device access count does not match the responses");

// the device sees the oldest outstanding request unchanged
dev_routed: assert property (@(posedge clk_sys) disable iff (reset)
	(dev_valid && dev_done) |-> (exp_count != 0 && exp_head.device &&
		dev_req.req == exp_head.req && dev_req.dev == exp_head.rsp.dev))
	else fail_now($sformatf("device request %h to device %0d, expected %h to device %0d",
		dev_req.req, dev_req.dev, exp_head.req, exp_head.rsp.dev));

task automatic apply_reset();
	reset <= 1'b1;
	repeat (3) @(posedge clk_sys);
	reset <= 1'b0;
endtask

task automatic send(logic write, logic [15:0] addr, io_port_pkg::io_size_e size,
	logic [31:0] data);
	int cycles;
	cycles = 0;
	req       <= '{write: write, address: addr, size: size, writedata: data};
	req_valid <= 1'b1;
	forever begin
		@(negedge clk_sys);
		if (req_ready) break;
		cycles++;
		if (cycles > 200) stop_run("timeout: request was never accepted");
	end
	@(posedge clk_sys);
	req_valid <= 1'b0;
endtask

task automatic drain();
	int cycles;
	cycles = 0;
	forever begin
		@(negedge clk_sys);
		if (exp_count == 0 && !rsp_valid) break;
		cycles++;
		if (cycles > 2000) stop_run("timeout: responses did not all come back");
	end
	@(posedge clk_sys);
endtask

initial begin
	void'($urandom(32'h3ac2));
	reset        = 1'b1;
	req          = '0;
	req_valid    = 1'b0;
	rsp_ready    = 1'b1;
	dev_done     = 1'b0;
	dev_rdata    = 32'd0;
	backpressure = 1'b0;
	addr_pool    = '{16'h1F0, 16'h3F6, 16'h172, 16'h3F5, 16'h0C4, 16'h0A1, 16'h061,
		16'h064, 16'h070, 16'h389, 16'h331, 16'h3B4, 16'h201, 16'h8888, 16'h0300, 16'hFFFF};
	repeat (3) @(posedge clk_sys);
	reset <= 1'b0;
	@(posedge clk_sys);

	// one read in every window, then unmapped
	send(0, 16'h01F3, io_port_pkg::size_dword, 0);
	send(0, 16'h0171, io_port_pkg::size_dword, 0);
	send(0, 16'h03F2, io_port_pkg::size_byte, 0);
	send(0, 16'h0008, io_port_pkg::size_byte, 0);
	send(0, 16'h0021, io_port_pkg::size_byte, 0);
	send(0, 16'h0040, io_port_pkg::size_byte, 0);
	send(0, 16'h0060, io_port_pkg::size_byte, 0);
	send(0, 16'h0071, io_port_pkg::size_byte, 0);
	send(0, 16'h0224, io_port_pkg::size_byte, 0);
	send(0, 16'h03F9, io_port_pkg::size_byte, 0);
	send(0, 16'h03C4, io_port_pkg::size_byte, 0);
	send(0, 16'h0201, io_port_pkg::size_byte, 0);
	send(0, 16'h8888, io_port_pkg::size_byte, 0);
	send(0, 16'h0300, io_port_pkg::size_byte, 0);
	drain();

	// key write, wrong key, byte write, then a later disk access
	send(1, 16'h8888, io_port_pkg::size_word, 32'h0000_A15C);
	send(1, 16'h8888, io_port_pkg::size_word, 32'h0000_775C);
	send(1, 16'h8888, io_port_pkg::size_byte, 32'h0000_A133);
	send(0, 16'h03F4, io_port_pkg::size_byte, 0);
	drain();

	apply_reset();
	@(posedge clk_sys);
	send(1, 16'h03F2, io_port_pkg::size_byte, 32'h0000_0011);
	drain();

	backpressure <= 1'b1;
	for (int i = 0; i < 60; i++) begin
		send($urandom % 2, addr_pool[$urandom % 16], io_port_pkg::io_size_e'($urandom % 3),
			(($urandom % 2) != 0) ? {16'd0, 8'hA1, 8'($urandom)} : $urandom);
	end
	drain();
	backpressure <= 1'b0;
	drain();

	$display("TESTBENCH PASSED");
	$finish;
end

endmodule

// ==== test/io_port_fabric_sva.sv ====
`timescale 1ns/100ps

module io_port_fabric_sva
#(
	parameter logic [7:0] SYSCFG_RESET = 8'hA2
)
(
	input                        clk_sys,
	input                        reset,
	input io_port_pkg::io_rsp_t  rsp,
	input                        rsp_valid,
	input                        rsp_ready,
	input io_port_pkg::io_dec_t  dev_req,
	input                        dev_valid,
	input                        dev_done,
	input [7:0]                  syscfg
);

rsp_held: assert property (@(posedge clk_sys) disable iff (reset)
	(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
	else $error("response changed while held");

dev_held: assert property (@(posedge clk_sys) disable iff (reset)
	(dev_valid && !dev_done) |=> (dev_valid && $stable(dev_req)))
	else $error("device request changed before completion");

// sysctl and unmapped ports are answered inside the fabric
dev_internal: assert property (@(posedge clk_sys) disable iff (reset)
	dev_valid |-> (dev_req.dev != io_port_pkg::dev_none &&
		dev_req.dev != io_port_pkg::dev_sysctl))
	else $error("device access for an internal port");

reset_state: assert property (@(posedge clk_sys)
	$fell(reset) |-> (syscfg == SYSCFG_RESET && !rsp_valid && !dev_valid))
	else $error("wrong state after reset");

endmodule

bind io_port_fabric io_port_fabric_sva
#(
	.SYSCFG_RESET (SYSCFG_RESET)
)
io_port_fabric_sva_i
(
	.clk_sys   (clk_sys),
	.reset     (reset),
	.rsp       (rsp),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.dev_req   (dev_req),
	.dev_valid (dev_valid),
	.dev_done  (dev_done),
	.syscfg    (syscfg)
);

// ==== logic/io_port_fabric.sv ====
`timescale 1ns/100ps

module io_port_fabric
#(
	parameter logic [7:0] SYSCFG_RESET = 8'hA2,
	parameter logic [7:0] SYSCTL_KEY   = 8'hA1
)
(
	input                         clk_sys,
	input                         reset,

	input  io_port_pkg::io_req_t  req,
	input                         req_valid,
	output logic                  req_ready,

	output io_port_pkg::io_rsp_t  rsp,
	output logic                  rsp_valid,
	input                         rsp_ready,

	output io_port_pkg::io_dec_t  dev_req,
	output logic                  dev_valid,
	input                         dev_done,
	input         [31:0]          dev_rdata,

	output        [7:0]           syscfg
);

io_port_pkg::io_req_t req_q;
logic                 req_q_valid;
logic                 req_q_ready;

io_port_pkg::io_dec_t dec_q;
logic                 dec_q_valid;
logic                 dec_q_ready;

io_request_stage io_request_stage_i
(
	.clk_sys    (clk_sys),
	.reset      (reset),
	.in         (req),
	.in_valid   (req_valid),
	.in_ready   (req_ready),
	.out        (req_q),
	.out_valid  (req_q_valid),
	.out_ready  (req_q_ready)
);

port_decode_stage port_decode_stage_i
(
	.clk_sys    (clk_sys),
	.reset      (reset),
	.in         (req_q),
	.in_valid   (req_q_valid),
	.in_ready   (req_q_ready),
	.out        (dec_q),
	.out_valid  (dec_q_valid),
	.out_ready  (dec_q_ready)
);

io_response_stage
#(
	.SYSCFG_RESET (SYSCFG_RESET),
	.SYSCTL_KEY   (SYSCTL_KEY)
)
io_response_stage_i
(
	.clk_sys    (clk_sys),
	.reset      (reset),
	.in         (dec_q),
	.in_valid   (dec_q_valid),
	.in_ready   (dec_q_ready),
	.dev_req    (dev_req),
	.dev_valid  (dev_valid),
	.dev_done   (dev_done),
	.dev_rdata  (dev_rdata),
	.rsp        (rsp),
	.rsp_valid  (rsp_valid),
	.rsp_ready  (rsp_ready),
	.syscfg     (syscfg)
);

endmodule

// ==== logic/io_response_stage.sv ====
`timescale 1ns/100ps

module io_response_stage
#(
	parameter logic [7:0] SYSCFG_RESET = 8'hA2,
	parameter logic [7:0] SYSCTL_KEY   = 8'hA1
)
(
	input                         clk_sys,
	input                         reset,

	input  io_port_pkg::io_dec_t  in,
	input                         in_valid,
	output logic                  in_ready,

	output io_port_pkg::io_dec_t  dev_req,
	output logic                  dev_valid,
	input                         dev_done,
	input         [31:0]          dev_rdata,

	output io_port_pkg::io_rsp_t  rsp,
	output logic                  rsp_valid,
	input                         rsp_ready,

	output        [7:0]           syscfg
);

typedef enum logic [1:0] {
	state_idle,
	state_device_wait,
	state_respond
} state_e;

state_e               state;
io_port_pkg::io_dec_t cur;
io_port_pkg::io_rsp_t rsp_q;
logic                 accept;
logic                 internal;
logic                 disk_access;
logic                 key_write;
logic [7:0]           ctlport;
logic                 in_reset;

function automatic logic [31:0] shape_rdata(io_port_pkg::io_dec_t dec, logic [31:0] raw);
	logic [31:0] data;
	if (dec.req.write) begin
		data = 32'd0;
	end
	else if (dec.dev == io_port_pkg::dev_ide0 || dec.dev == io_port_pkg::dev_ide1) begin
		data = raw;
	end
	else if (dec.dev == io_port_pkg::dev_none || dec.dev == io_port_pkg::dev_sysctl) begin
		data = {24'd0, io_port_pkg::UNMAPPED_DATA};
	end
	else begin
		data = {24'd0, raw[7:0]};
	end
	return data;
endfunction

// a new request may enter while the previous response is being taken
assign in_ready = (state == state_idle) || (state == state_respond && rsp_ready);
assign accept   = in_valid && in_ready;

// sysctl and unmapped ports are answered here and never reach the device bus
assign internal = (in.dev == io_port_pkg::dev_none) || (in.dev == io_port_pkg::dev_sysctl);

assign disk_access = (in.dev == io_port_pkg::dev_ide0) ||
	(in.dev == io_port_pkg::dev_ide1) ||
	(in.dev == io_port_pkg::dev_floppy);

assign key_write = in.req.write && (in.dev == io_port_pkg::dev_sysctl) &&
	(in.req.size == io_port_pkg::size_word) && (in.req.writedata[15:8] == SYSCTL_KEY);

always_ff @(posedge clk_sys) begin
	if (reset) begin
		state <= state_idle;
	end
	else if (accept) begin
		state <= internal ? state_respond : state_device_wait;
	end
	else if (state == state_device_wait && dev_done) begin
		state <= state_respond;
	end
	else if (state == state_respond && rsp_ready) begin
		state <= state_idle;
	end
end

always_ff @(posedge clk_sys) begin
	if (accept) begin
		cur <= in;
	end
	if (accept && internal) begin
		rsp_q <= '{write: in.req.write, dev: in.dev, readdata: shape_rdata(in, 32'd0)};
	end
	else if (state == state_device_wait && dev_done) begin
		rsp_q <= '{write: cur.req.write, dev: cur.dev, readdata: shape_rdata(cur, dev_rdata)};
	end
end

// the firmware sees the power-on value until a disk controller is touched
always_ff @(posedge clk_sys) begin
	if (reset) begin
		ctlport  <= SYSCFG_RESET;
		in_reset <= 1'b1;
	end
	else if (accept && disk_access && in_reset) begin
		ctlport  <= 8'd0;
		in_reset <= 1'b0;
	end
	else if (accept && key_write) begin
		ctlport  <= in.req.writedata[7:0];
		in_reset <= 1'b0;
	end
end

assign dev_req   = cur;
assign dev_valid = (state == state_device_wait);

assign rsp       = rsp_q;
assign rsp_valid = (state == state_respond);

assign syscfg    = ctlport;

endmodule

// ==== logic/port_decode_stage.sv ====
`timescale 1ns/100ps

module port_decode_stage
(
	input                         clk_sys,
	input                         reset,

	input  io_port_pkg::io_req_t  in,
	input                         in_valid,
	output logic                  in_ready,

	output io_port_pkg::io_dec_t  out,
	output logic                  out_valid,
	input                         out_ready
);

io_port_pkg::io_dev_e dev_sel;
io_port_pkg::io_dec_t held;
logic                 held_valid;
logic                 take;
logic [15:0]          addr;

assign addr = in.address;

// windows overlap at 0x3F6 (ide0 over floppy) and 0x061 (pit over ps2),
// so the order of this chain matters
always_comb begin
	dev_sel = io_port_pkg::dev_none;
	if (io_port_pkg::in_window(addr, io_port_pkg::IDE0_CMD) ||
		io_port_pkg::in_window(addr, io_port_pkg::IDE0_CTL)) begin
		dev_sel = io_port_pkg::dev_ide0;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::IDE1_CMD) ||
		io_port_pkg::in_window(addr, io_port_pkg::IDE1_CTL)) begin
		dev_sel = io_port_pkg::dev_ide1;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::FLOPPY)) begin
		dev_sel = io_port_pkg::dev_floppy;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::DMA_SLAVE) ||
		io_port_pkg::in_window(addr, io_port_pkg::DMA_PAGE) ||
		io_port_pkg::in_window(addr, io_port_pkg::DMA_MASTER)) begin
		dev_sel = io_port_pkg::dev_dma;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::PIC_MASTER) ||
		io_port_pkg::in_window(addr, io_port_pkg::PIC_SLAVE)) begin
		dev_sel = io_port_pkg::dev_pic;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::PIT_TIMER) ||
		io_port_pkg::in_window(addr, io_port_pkg::PIT_SPKR)) begin
		dev_sel = io_port_pkg::dev_pit;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::PS2_IO) ||
		io_port_pkg::in_window(addr, io_port_pkg::PS2_CTL)) begin
		dev_sel = io_port_pkg::dev_ps2;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::RTC)) begin
		dev_sel = io_port_pkg::dev_rtc;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::SOUND_SB) ||
		io_port_pkg::in_window(addr, io_port_pkg::SOUND_FM)) begin
		dev_sel = io_port_pkg::dev_sound;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::UART) ||
		io_port_pkg::in_window(addr, io_port_pkg::UART_MPU)) begin
		dev_sel = io_port_pkg::dev_uart;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::VGA_B) ||
		io_port_pkg::in_window(addr, io_port_pkg::VGA_C) ||
		io_port_pkg::in_window(addr, io_port_pkg::VGA_D)) begin
		dev_sel = io_port_pkg::dev_vga;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::JOYSTICK)) begin
		dev_sel = io_port_pkg::dev_joystick;
	end
	else if (io_port_pkg::in_window(addr, io_port_pkg::SYSCTL)) begin
		dev_sel = io_port_pkg::dev_sysctl;
	end
end

assign in_ready = !held_valid || out_ready;
assign take     = in_valid && in_ready;

always_ff @(posedge clk_sys) begin
	if (reset) begin
		held_valid <= 1'b0;
	end
	else if (take) begin
		held_valid <= 1'b1;
	end
	else if (out_ready) begin
		held_valid <= 1'b0;
	end
end

always_ff @(posedge clk_sys) begin
	if (take) begin
		held <= '{req: in, dev: dev_sel};
	end
end

assign out       = held;
assign out_valid = held_valid;

endmodule

// ==== logic/io_request_stage.sv ====
`timescale 1ns/100ps

module io_request_stage
(
	input                         clk_sys,
	input                         reset,

	input  io_port_pkg::io_req_t  in,
	input                         in_valid,
	output logic                  in_ready,

	output io_port_pkg::io_req_t  out,
	output logic                  out_valid,
	input                         out_ready
);

io_port_pkg::io_req_t held;
logic                 held_valid;
logic                 take;

// the slot frees up in the same cycle that the next stage takes it
assign in_ready = !held_valid || out_ready;
assign take     = in_valid && in_ready;

always_ff @(posedge clk_sys) begin
	if (reset) begin
		held_valid <= 1'b0;
	end
	else if (take) begin
		held_valid <= 1'b1;
	end
	else if (out_ready) begin
		held_valid <= 1'b0;
	end
end

always_ff @(posedge clk_sys) begin
	if (take) begin
		held <= in;
	end
end

assign out       = held;
assign out_valid = held_valid;

endmodule

// ==== logic/io_port_pkg.sv ====
package io_port_pkg;

	// access size, encoded as log2 of the transfer length in bytes
	typedef enum logic [1:0] {
		size_byte  = 2'd0,
		size_word  = 2'd1,
		size_dword = 2'd2
	} io_size_e;

	// order follows the decode priority
	typedef enum logic [3:0] {
		dev_none     = 4'd0,
		dev_ide0     = 4'd1,
		dev_ide1     = 4'd2,
		dev_floppy   = 4'd3,
		dev_dma      = 4'd4,
		dev_pic      = 4'd5,
		dev_pit      = 4'd6,
		dev_ps2      = 4'd7,
		dev_rtc      = 4'd8,
		dev_sound    = 4'd9,
		dev_uart     = 4'd10,
		dev_vga      = 4'd11,
		dev_joystick = 4'd12,
		dev_sysctl   = 4'd13
	} io_dev_e;

	typedef struct packed {
		logic        write;
		logic [15:0] address;
		io_size_e    size;
		logic [31:0] writedata;
	} io_req_t;

	typedef struct packed {
		io_req_t req;
		io_dev_e dev;
	} io_dec_t;

	typedef struct packed {
		logic        write;
		io_dev_e     dev;
		logic [31:0] readdata;
	} io_rsp_t;

	// span is a power of two and base is aligned to it
	typedef struct packed {
		logic [15:0] base;
		logic [15:0] span;
	} io_window_t;

	localparam io_window_t IDE0_CMD   = '{base: 16'h01F0, span: 16'd8};
	localparam io_window_t IDE0_CTL   = '{base: 16'h03F6, span: 16'd2};
	localparam io_window_t IDE1_CMD   = '{base: 16'h0170, span: 16'd8};
	localparam io_window_t IDE1_CTL   = '{base: 16'h0376, span: 16'd2};
	localparam io_window_t FLOPPY     = '{base: 16'h03F0, span: 16'd8};
	localparam io_window_t DMA_SLAVE  = '{base: 16'h0000, span: 16'd16};
	localparam io_window_t DMA_PAGE   = '{base: 16'h0080, span: 16'd16};
	localparam io_window_t DMA_MASTER = '{base: 16'h00C0, span: 16'd32};
	localparam io_window_t PIC_MASTER = '{base: 16'h0020, span: 16'd2};
	localparam io_window_t PIC_SLAVE  = '{base: 16'h00A0, span: 16'd2};
	localparam io_window_t PIT_TIMER  = '{base: 16'h0040, span: 16'd4};
	localparam io_window_t PIT_SPKR   = '{base: 16'h0061, span: 16'd1};
	localparam io_window_t PS2_IO     = '{base: 16'h0060, span: 16'd8};
	localparam io_window_t PS2_CTL    = '{base: 16'h0090, span: 16'd16};
	localparam io_window_t RTC        = '{base: 16'h0070, span: 16'd2};
	localparam io_window_t SOUND_SB   = '{base: 16'h0220, span: 16'd16};
	localparam io_window_t SOUND_FM   = '{base: 16'h0388, span: 16'd4};
	localparam io_window_t UART       = '{base: 16'h03F8, span: 16'd8};
	localparam io_window_t UART_MPU   = '{base: 16'h0330, span: 16'd2};
	localparam io_window_t VGA_B      = '{base: 16'h03B0, span: 16'd16};
	localparam io_window_t VGA_C      = '{base: 16'h03C0, span: 16'd16};
	localparam io_window_t VGA_D      = '{base: 16'h03D0, span: 16'd16};
	localparam io_window_t JOYSTICK   = '{base: 16'h0201, span: 16'd1};
	localparam io_window_t SYSCTL     = '{base: 16'h8888, span: 16'd1};

	localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

	function automatic logic in_window(logic [15:0] address, io_window_t window);
		return (address & ~(window.span - 16'd1)) == window.base;
	endfunction

endpackage
